// File: source/secv_cfg_pkg.sv
// Widths for a 64-bit core with a 16-bit byte address; WORD_OFS_BITS must equal log2 of SEL_WIDTH
package secv_cfg_pkg;

    // Data path width in bits
    localparam int XLEN = 64;

    // One byte select per data byte
    localparam int SEL_WIDTH = XLEN / 8;

    // Byte address as seen at the request port
    localparam int ADR_WIDTH = 16;

    // Byte position inside one doubleword
    localparam int WORD_OFS_BITS = 3;

endpackage

// File: source/secv_mem_pkg.sv
// Opcode layout is {is_store, is_unsigned, size}; stores with is_unsigned and LD unsigned are illegal
package secv_mem_pkg;

    typedef struct packed {
        logic       is_store;
        logic       is_unsigned;
        logic [1:0] size;
    } mem_op_fields_t;

    // Raw view for the legality table, field view for size and extension
    typedef union packed {
        logic [3:0]     raw;
        mem_op_fields_t f;
    } mem_op_u;

    // Access size codes
    localparam logic [1:0] SIZE_B = 2'd0;
    localparam logic [1:0] SIZE_H = 2'd1;
    localparam logic [1:0] SIZE_W = 2'd2;
    localparam logic [1:0] SIZE_D = 2'd3;

    // Loads
    localparam logic [3:0] MEM_OP_LB  = 4'b0000;
    localparam logic [3:0] MEM_OP_LH  = 4'b0001;
    localparam logic [3:0] MEM_OP_LW  = 4'b0010;
    localparam logic [3:0] MEM_OP_LD  = 4'b0011;
    localparam logic [3:0] MEM_OP_LBU = 4'b0100;
    localparam logic [3:0] MEM_OP_LHU = 4'b0101;
    localparam logic [3:0] MEM_OP_LWU = 4'b0110;

    // Stores
    localparam logic [3:0] MEM_OP_SB  = 4'b1000;
    localparam logic [3:0] MEM_OP_SH  = 4'b1001;
    localparam logic [3:0] MEM_OP_SW  = 4'b1010;
    localparam logic [3:0] MEM_OP_SD  = 4'b1011;

    function automatic logic op_legal(mem_op_u op);
        case (op.raw)
            MEM_OP_LB, MEM_OP_LH, MEM_OP_LW, MEM_OP_LD,
            MEM_OP_LBU, MEM_OP_LHU, MEM_OP_LWU,
            MEM_OP_SB, MEM_OP_SH, MEM_OP_SW, MEM_OP_SD: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [3:0] op_bytes(mem_op_u op);
        return 4'd1 << op.f.size;
    endfunction

    function automatic logic [secv_cfg_pkg::SEL_WIDTH-1:0] op_sel(
        logic [1:0]                             size,
        logic [secv_cfg_pkg::WORD_OFS_BITS-1:0] ofs
    );
        logic [secv_cfg_pkg::SEL_WIDTH-1:0] mask;
        case (size)
            SIZE_B:  mask = 'h01;
            SIZE_H:  mask = 'h03;
            SIZE_W:  mask = 'h0f;
            default: mask = 'hff;
        endcase
        return mask << ofs;
    endfunction

    // Value already shifted down so the addressed bytes sit at bit 0
    function automatic logic [secv_cfg_pkg::XLEN-1:0] load_extend(
        mem_op_u                       op,
        logic [secv_cfg_pkg::XLEN-1:0] val
    );
        logic [secv_cfg_pkg::XLEN-1:0] res;
        logic                          sgn;
        case (op.f.size)
            SIZE_B: begin
                sgn = val[7] && !op.f.is_unsigned;
                res = {{(secv_cfg_pkg::XLEN-8){sgn}}, val[7:0]};
            end
            SIZE_H: begin
                sgn = val[15] && !op.f.is_unsigned;
                res = {{(secv_cfg_pkg::XLEN-16){sgn}}, val[15:0]};
            end
            SIZE_W: begin
                sgn = val[31] && !op.f.is_unsigned;
                res = {{(secv_cfg_pkg::XLEN-32){sgn}}, val[31:0]};
            end
            SIZE_D: begin
                sgn = 1'b0;
                res = val;
            end
        endcase
        return res;
    endfunction

endpackage

// File: source/mem_dispatch.sv
// Needs N_LANES and BANK_WORDS to be powers of two, both at least 2; holds one request at a time
module mem_dispatch #(
    parameter int N_LANES    = 4,
    parameter int BANK_WORDS = 16
) (
    input  logic                                     clk_i,
    input  logic                                     arst_n_i,

    input  logic                                     req_valid_i,
    output logic                                     req_ready_o,
    input  secv_mem_pkg::mem_op_u                    req_op_i,
    input  logic [secv_cfg_pkg::ADR_WIDTH-1:0]       req_adr_i,
    input  logic [secv_cfg_pkg::XLEN-1:0]            req_dat_i,

    output logic [N_LANES-1:0]                       lane_valid_o,
    input  logic [N_LANES-1:0]                       lane_ready_i,
    output secv_mem_pkg::mem_op_u                    lane_op_o,
    output logic [$clog2(BANK_WORDS)-1:0]            lane_word_o,
    output logic [secv_cfg_pkg::WORD_OFS_BITS-1:0]   lane_ofs_o,
    output logic [secv_cfg_pkg::XLEN-1:0]            lane_dat_o,
    output logic                                     lane_err_o,

    output logic                                     order_push_o,
    output logic [$clog2(N_LANES)-1:0]               order_lane_o,
    input  logic                                     order_full_i
);

    localparam int OFS_BITS  = secv_cfg_pkg::WORD_OFS_BITS;
    localparam int LANE_BITS = $clog2(N_LANES);
    localparam int WORD_BITS = $clog2(BANK_WORDS);
    localparam int SPAN_BITS = OFS_BITS + LANE_BITS + WORD_BITS;

    logic [OFS_BITS-1:0]  ofs_d;
    logic [LANE_BITS-1:0] lane_raw;
    logic [LANE_BITS-1:0] lane_d;
    logic [WORD_BITS-1:0] word_d;
    logic                 range_err;
    logic                 align_err;
    logic                 err_d;
    logic                 issue;

    logic                 valid_q;
    logic [LANE_BITS-1:0] lane_q;

    // Address split: offset, then lane, then bank word
    assign ofs_d    = req_adr_i[OFS_BITS-1:0];
    assign lane_raw = req_adr_i[OFS_BITS +: LANE_BITS];
    assign word_d   = req_adr_i[OFS_BITS + LANE_BITS +: WORD_BITS];

    assign range_err = (req_adr_i >> SPAN_BITS) != '0;
    assign align_err = (ofs_d & OFS_BITS'(secv_mem_pkg::op_bytes(req_op_i) - 4'd1)) != '0;
    assign err_d     = !secv_mem_pkg::op_legal(req_op_i) || align_err || range_err;

    // Out-of-range requests still answer, through lane 0
    assign lane_d = range_err ? '0 : lane_raw;

    assign issue       = valid_q && !order_full_i && lane_ready_i[lane_q];
    assign req_ready_o = !valid_q || issue;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (req_ready_o) begin
            valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            lane_q      <= lane_d;
            lane_op_o   <= req_op_i;
            lane_word_o <= word_d;
            lane_ofs_o  <= ofs_d;
            lane_dat_o  <= req_dat_i;
            lane_err_o  <= err_d;
        end
    end

    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            lane_valid_o[i] = valid_q && !order_full_i && (lane_q == LANE_BITS'(i));
        end
    end

    // Order entry goes in with the lane handshake
    assign order_push_o = issue;
    assign order_lane_o = lane_q;

endmodule

// File: source/mem_lane.sv
// BANK_WORDS must be a power of two; bank contents clear on reset and errors never touch them
module mem_lane #(
    parameter int BANK_WORDS = 16
) (
    input  logic                                   clk_i,
    input  logic                                   arst_n_i,

    input  logic                                   in_valid_i,
    output logic                                   in_ready_o,
    input  secv_mem_pkg::mem_op_u                  in_op_i,
    input  logic [$clog2(BANK_WORDS)-1:0]          in_word_i,
    input  logic [secv_cfg_pkg::WORD_OFS_BITS-1:0] in_ofs_i,
    input  logic [secv_cfg_pkg::XLEN-1:0]          in_dat_i,
    input  logic                                   in_err_i,

    output logic                                   out_valid_o,
    input  logic                                   out_ready_i,
    output logic [secv_cfg_pkg::XLEN-1:0]          out_dat_o,
    output logic                                   out_wb_o,
    output logic                                   out_err_o
);

    localparam int XLEN = secv_cfg_pkg::XLEN;

    logic [XLEN-1:0]                    bank [BANK_WORDS];
    logic [XLEN-1:0]                    wr_dat;
    logic [XLEN-1:0]                    rd_dat;
    logic [secv_cfg_pkg::SEL_WIDTH-1:0] wr_sel;
    logic                               accept;
    logic                               is_load;
    logic                               do_write;

    logic                               out_valid_q;
    logic                               out_wb_q;
    logic                               out_err_q;
    logic [XLEN-1:0]                    out_dat_q;

    // Ready while the response slot is free or draining
    assign in_ready_o = !out_valid_q || out_ready_i;
    assign accept     = in_valid_i && in_ready_o;

    assign is_load  = !in_op_i.f.is_store;
    assign do_write = accept && !in_err_i && in_op_i.f.is_store;

    // Store bytes move up to the offset, load bytes move down to bit 0
    assign wr_sel = secv_mem_pkg::op_sel(in_op_i.f.size, in_ofs_i);
    assign wr_dat = in_dat_i << {in_ofs_i, 3'b000};
    assign rd_dat = bank[in_word_i] >> {in_ofs_i, 3'b000};

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int w = 0; w < BANK_WORDS; w++) begin
                bank[w] <= '0;
            end
        end else if (do_write) begin
            for (int b = 0; b < secv_cfg_pkg::SEL_WIDTH; b++) begin
                if (wr_sel[b]) begin
                    bank[in_word_i][8*b +: 8] <= wr_dat[8*b +: 8];
                end
            end
        end
    end

    // Response slot
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_valid_q <= 1'b0;
            out_wb_q    <= 1'b0;
            out_err_q   <= 1'b0;
        end else if (accept) begin
            out_valid_q <= 1'b1;
            out_wb_q    <= is_load && !in_err_i;
            out_err_q   <= in_err_i;
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    // Stores and errors answer with zero data
    always_ff @(posedge clk_i) begin
        if (accept) begin
            if (in_err_i || !is_load) begin
                out_dat_q <= '0;
            end else begin
                out_dat_q <= secv_mem_pkg::load_extend(in_op_i, rd_dat);
            end
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_dat_o   = out_dat_q;
    assign out_wb_o    = out_wb_q;
    assign out_err_o   = out_err_q;

endmodule

// File: source/mem_collect.sv
// Order queue holds 4 lane indices; the dispatcher must not push while order_full_o is high
module mem_collect #(
    parameter int N_LANES = 4
) (
    input  logic                                      clk_i,
    input  logic                                      arst_n_i,

    input  logic                                      order_push_i,
    input  logic [$clog2(N_LANES)-1:0]                order_lane_i,
    output logic                                      order_full_o,

    input  logic [N_LANES-1:0]                        lrsp_valid_i,
    output logic [N_LANES-1:0]                        lrsp_ready_o,
    input  logic [N_LANES-1:0][secv_cfg_pkg::XLEN-1:0] lrsp_dat_i,
    input  logic [N_LANES-1:0]                        lrsp_wb_i,
    input  logic [N_LANES-1:0]                        lrsp_err_i,

    output logic                                      rsp_valid_o,
    input  logic                                      rsp_ready_i,
    output logic [secv_cfg_pkg::XLEN-1:0]             rsp_dat_o,
    output logic                                      rsp_wb_o,
    output logic                                      rsp_err_o
);

    localparam int LANE_BITS = $clog2(N_LANES);
    localparam int DEPTH     = 4;
    localparam int PTR_BITS  = $clog2(DEPTH);

    logic [LANE_BITS-1:0] fifo_q [DEPTH];
    logic [PTR_BITS-1:0]  wr_ptr_q;
    logic [PTR_BITS-1:0]  rd_ptr_q;
    logic [PTR_BITS:0]    count_q;
    logic [LANE_BITS-1:0] head;
    logic                 empty;
    logic                 push;
    logic                 pop;

    assign empty        = (count_q == '0);
    assign order_full_o = (count_q == (PTR_BITS+1)'(DEPTH));
    assign head         = fifo_q[rd_ptr_q];

    assign push = order_push_i && !order_full_o;
    assign pop  = rsp_valid_o && rsp_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_q[wr_ptr_q] <= order_lane_i;
        end
    end

    // Only the head lane is visible and acknowledged
    assign rsp_valid_o = !empty && lrsp_valid_i[head];
    assign rsp_dat_o   = lrsp_dat_i[head];
    assign rsp_wb_o    = lrsp_wb_i[head];
    assign rsp_err_o   = lrsp_err_i[head];

    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            lrsp_ready_o[i] = !empty && rsp_ready_i && (head == LANE_BITS'(i));
        end
    end

endmodule

// File: source/mem_subsys_top.sv
// N_LANES and BANK_WORDS must be powers of two, at least 2, and their byte span must fit ADR_WIDTH
module mem_subsys_top #(
    parameter int N_LANES    = 4,
    parameter int BANK_WORDS = 16
) (
    input  logic                               clk_i,
    input  logic                               arst_n_i,

    input  logic                               req_valid_i,
    output logic                               req_ready_o,
    input  secv_mem_pkg::mem_op_u              req_op_i,
    input  logic [secv_cfg_pkg::ADR_WIDTH-1:0] req_adr_i,
    input  logic [secv_cfg_pkg::XLEN-1:0]      req_dat_i,

    output logic                               rsp_valid_o,
    input  logic                               rsp_ready_i,
    output logic [secv_cfg_pkg::XLEN-1:0]      rsp_dat_o,
    output logic                               rsp_wb_o,
    output logic                               rsp_err_o
);

    localparam int XLEN = secv_cfg_pkg::XLEN;

    // Dispatcher to lanes
    logic [N_LANES-1:0]                       lane_valid;
    logic [N_LANES-1:0]                       lane_ready;
    secv_mem_pkg::mem_op_u                    lane_op;
    logic [$clog2(BANK_WORDS)-1:0]            lane_word;
    logic [secv_cfg_pkg::WORD_OFS_BITS-1:0]   lane_ofs;
    logic [XLEN-1:0]                          lane_dat;
    logic                                     lane_err;

    // Dispatcher to collector
    logic                                     order_push;
    logic [$clog2(N_LANES)-1:0]               order_lane;
    logic                                     order_full;

    // Lanes to collector
    logic [N_LANES-1:0]                       lrsp_valid;
    logic [N_LANES-1:0]                       lrsp_ready;
    logic [N_LANES-1:0][XLEN-1:0]             lrsp_dat;
    logic [N_LANES-1:0]                       lrsp_wb;
    logic [N_LANES-1:0]                       lrsp_err;

    mem_dispatch #(
        .N_LANES    (N_LANES),
        .BANK_WORDS (BANK_WORDS)
    ) u_dispatch (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_op_i     (req_op_i),
        .req_adr_i    (req_adr_i),
        .req_dat_i    (req_dat_i),
        .lane_valid_o (lane_valid),
        .lane_ready_i (lane_ready),
        .lane_op_o    (lane_op),
        .lane_word_o  (lane_word),
        .lane_ofs_o   (lane_ofs),
        .lane_dat_o   (lane_dat),
        .lane_err_o   (lane_err),
        .order_push_o (order_push),
        .order_lane_o (order_lane),
        .order_full_i (order_full)
    );

    for (genvar g = 0; g < N_LANES; g++) begin : g_lane
        mem_lane #(
            .BANK_WORDS (BANK_WORDS)
        ) u_lane (
            .clk_i       (clk_i),
            .arst_n_i    (arst_n_i),
            .in_valid_i  (lane_valid[g]),
            .in_ready_o  (lane_ready[g]),
            .in_op_i     (lane_op),
            .in_word_i   (lane_word),
            .in_ofs_i    (lane_ofs),
            .in_dat_i    (lane_dat),
            .in_err_i    (lane_err),
            .out_valid_o (lrsp_valid[g]),
            .out_ready_i (lrsp_ready[g]),
            .out_dat_o   (lrsp_dat[g]),
            .out_wb_o    (lrsp_wb[g]),
            .out_err_o   (lrsp_err[g])
        );
    end

    mem_collect #(
        .N_LANES (N_LANES)
    ) u_collect (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .order_push_i (order_push),
        .order_lane_i (order_lane),
        .order_full_o (order_full),
        .lrsp_valid_i (lrsp_valid),
        .lrsp_ready_o (lrsp_ready),
        .lrsp_dat_i   (lrsp_dat),
        .lrsp_wb_i    (lrsp_wb),
        .lrsp_err_i   (lrsp_err),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_ready_i  (rsp_ready_i),
        .rsp_dat_o    (rsp_dat_o),
        .rsp_wb_o     (rsp_wb_o),
        .rsp_err_o    (rsp_err_o)
    );

endmodule

// File: bench/mem_subsys_sva.sv
// Checks only the external ports of mem_subsys_top; rsp payload is assumed known while valid
module mem_subsys_sva (
    input logic                          clk_i,
    input logic                          arst_n_i,
    input logic                          req_ready_i,
    input logic                          rsp_valid_i,
    input logic                          rsp_ready_i,
    input logic [secv_cfg_pkg::XLEN-1:0] rsp_dat_i,
    input logic                          rsp_wb_i,
    input logic                          rsp_err_i
);

    // Held response keeps valid and payload until it is taken
    rsp_hold_a: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_dat_i)
            && $stable(rsp_wb_i) && $stable(rsp_err_i)
    ) else $error("rsp_valid_o or its payload changed while rsp_ready_i was low");

    ready_after_reset_a: assert property (
        @(posedge clk_i) $rose(arst_n_i) |-> req_ready_i
    ) else $error("req_ready_o was low right after reset release");

    // Error responses never write back
    err_no_wb_a: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        rsp_valid_i && rsp_err_i |-> !rsp_wb_i
    ) else $error("rsp_wb_o was high on an error response");

endmodule

bind mem_subsys_top mem_subsys_sva u_sva (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_ready_i (req_ready_o),
    .rsp_valid_i (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_dat_i   (rsp_dat_o),
    .rsp_wb_i    (rsp_wb_o),
    .rsp_err_i   (rsp_err_o)
);

// File: bench/mem_subsys_tb.sv
// Built for N_LANES 4 and BANK_WORDS 16; the byte model covers only that 512-byte space
module mem_subsys_tb;

    localparam int N_LANES      = 4;
    localparam int BANK_WORDS   = 16;
    localparam int XLEN         = secv_cfg_pkg::XLEN;
    localparam int ADR_WIDTH    = secv_cfg_pkg::ADR_WIDTH;
    localparam int MEM_BYTES    = N_LANES * BANK_WORDS * 8;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 3;
    localparam int N_BURST      = 32;

    // Cycle length of each test
    localparam int LEN_SIZES   = 24;
    localparam int LEN_SELECT  = 8;
    localparam int LEN_ERRORS  = 14;
    localparam int LEN_ORDER   = 40;
    localparam int LEN_STALL   = 160;
    localparam int LEN_LATENCY = 6;
    localparam int TEST_CYCLES = LEN_SIZES + LEN_SELECT + LEN_ERRORS + LEN_ORDER
                                 + LEN_STALL + LEN_LATENCY;

    logic                  clk_i;
    logic                  arst_n_i;
    logic                  req_valid_i;
    logic                  req_ready_o;
    secv_mem_pkg::mem_op_u req_op_i;
    logic [ADR_WIDTH-1:0]  req_adr_i;
    logic [XLEN-1:0]       req_dat_i;
    logic                  rsp_valid_o;
    logic                  rsp_ready_i;
    logic [XLEN-1:0]       rsp_dat_o;
    logic                  rsp_wb_o;
    logic                  rsp_err_o;

    // Byte model of all banks
    logic [7:0]           model [];

    // Requests to send and their predicted responses, in request order
    logic [3:0]           op_q [$];
    logic [ADR_WIDTH-1:0] adr_q [$];
    logic [XLEN-1:0]      dat_q [$];
    logic [XLEN-1:0]      exp_dat_q [$];
    logic                 exp_wb_q [$];
    logic                 exp_err_q [$];

    logic [3:0]           legal_ops [$];
    int                   rcv_count;
    bit                   saw_req_stall;

    mem_subsys_top #(
        .N_LANES    (N_LANES),
        .BANK_WORDS (BANK_WORDS)
    ) dut (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_op_i    (req_op_i),
        .req_adr_i   (req_adr_i),
        .req_dat_i   (req_dat_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_dat_o   (rsp_dat_o),
        .rsp_wb_o    (rsp_wb_o),
        .rsp_err_o   (rsp_err_o)
    );

    initial begin
        clk_i = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // Queue one request and predict its response from the byte model
    function automatic void add_req(input logic [3:0] op, input logic [ADR_WIDTH-1:0] adr,
                                    input logic [XLEN-1:0] dat);
        int              nbytes;
        int              a;
        bit              legal;
        bit              err;
        logic [XLEN-1:0] val;
        nbytes = 1 << op[1:0];
        a      = int'(adr);
        legal  = !(op[3] && op[2]) && (op != 4'b0111);
        err    = !legal || (a % nbytes != 0) || (a >= MEM_BYTES);
        val    = '0;
        if (!err && op[3]) begin
            for (int i = 0; i < nbytes; i++) begin
                model[a + i] = 8'(dat >> (8 * i));
            end
        end else if (!err) begin
            for (int i = nbytes - 1; i >= 0; i--) begin
                val = (val << 8) | XLEN'(model[a + i]);
            end
            // Signed loads narrower than a doubleword copy their top bit upward
            if (!op[2] && nbytes < 8 && ((val >> (8 * nbytes - 1)) & 64'd1) != 0) begin
                val = val | ~((64'd1 << (8 * nbytes)) - 64'd1);
            end
        end
        op_q.push_back(op);
        adr_q.push_back(adr);
        dat_q.push_back(dat);
        exp_dat_q.push_back(val);
        exp_wb_q.push_back(!err && !op[3]);
        exp_err_q.push_back(err);
    endfunction

    task automatic check_response();
        check_data("rsp_dat_o", rsp_dat_o, exp_dat_q.pop_front());
        check_flag("rsp_wb_o", rsp_wb_o, exp_wb_q.pop_front());
        check_flag("rsp_err_o", rsp_err_o, exp_err_q.pop_front());
    endtask

    task automatic send_all(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk_i);
            req_valid_i <= 1'b1;
            req_op_i    <= op_q.pop_front();
            req_adr_i   <= adr_q.pop_front();
            req_dat_i   <= dat_q.pop_front();
            @(negedge clk_i);
            while (!req_ready_o) begin
                saw_req_stall = 1'b1;
                @(negedge clk_i);
            end
        end
        @(posedge clk_i);
        req_valid_i <= 1'b0;
    endtask

    // Transfer is decided at the next rising edge, so the negedge view is final
    task automatic receive_all(input int n);
        while (rcv_count < n) begin
            @(negedge clk_i);
            if (rsp_valid_o && rsp_ready_i) begin
                check_response();
                rcv_count++;
            end
        end
    endtask

    task automatic drive_ready(input int n, input bit stall);
        while (rcv_count < n) begin
            @(posedge clk_i);
            if (stall) begin
                rsp_ready_i <= ($urandom_range(3) == 0);
            end else begin
                rsp_ready_i <= 1'b1;
            end
        end
        rsp_ready_i <= 1'b1;
    endtask

    task automatic run_batch(input bit stall);
        int n;
        n         = op_q.size();
        rcv_count = 0;
        fork
            send_all(n);
            receive_all(n);
            drive_ready(n, stall);
        join
    endtask

    task automatic test_sizes();
        add_req(secv_mem_pkg::MEM_OP_SD, 16'h0000, 64'h89ab_cdef_f012_3456);
        add_req(secv_mem_pkg::MEM_OP_SW, 16'h0008, 64'hdead_beef_8765_4321);
        add_req(secv_mem_pkg::MEM_OP_SH, 16'h0010, 64'h1111_2222_3333_9abc);
        add_req(secv_mem_pkg::MEM_OP_SB, 16'h0018, 64'h4444_5555_6666_77f7);
        add_req(secv_mem_pkg::MEM_OP_LD, 16'h0000, '0);
        add_req(secv_mem_pkg::MEM_OP_LW, 16'h0000, '0);
        add_req(secv_mem_pkg::MEM_OP_LWU, 16'h0000, '0);
        add_req(secv_mem_pkg::MEM_OP_LW, 16'h0004, '0);
        add_req(secv_mem_pkg::MEM_OP_LD, 16'h0008, '0);
        add_req(secv_mem_pkg::MEM_OP_LW, 16'h0008, '0);
        add_req(secv_mem_pkg::MEM_OP_LWU, 16'h0008, '0);
        add_req(secv_mem_pkg::MEM_OP_LH, 16'h0010, '0);
        add_req(secv_mem_pkg::MEM_OP_LHU, 16'h0010, '0);
        add_req(secv_mem_pkg::MEM_OP_LB, 16'h0018, '0);
        add_req(secv_mem_pkg::MEM_OP_LBU, 16'h0018, '0);
        add_req(secv_mem_pkg::MEM_OP_LH, 16'h0002, '0);
        add_req(secv_mem_pkg::MEM_OP_LB, 16'h0001, '0);
        run_batch(1'b0);
    endtask

    task automatic test_byte_selects();
        add_req(secv_mem_pkg::MEM_OP_SD, 16'h0020, 64'h1122_3344_5566_7788);
        add_req(secv_mem_pkg::MEM_OP_SB, 16'h0023, 64'hffff_ffff_ffff_ffa5);
        add_req(secv_mem_pkg::MEM_OP_SH, 16'h0026, 64'hffff_ffff_ffff_beef);
        add_req(secv_mem_pkg::MEM_OP_LD, 16'h0020, '0);
        run_batch(1'b0);
    endtask

    task automatic test_errors();
        add_req(secv_mem_pkg::MEM_OP_SD, 16'h0028, 64'h0123_4567_89ab_cdef);
        // LD with the unsigned bit, then a store with it
        add_req(4'b0111, 16'h0028, '0);
        add_req(4'b1100, 16'h0028, 64'hffff_ffff_ffff_ffff);
        add_req(secv_mem_pkg::MEM_OP_LW, 16'h002a, '0);
        add_req(secv_mem_pkg::MEM_OP_SW, 16'h002a, 64'hffff_ffff_ffff_ffff);
        add_req(secv_mem_pkg::MEM_OP_SD, 16'h0200, 64'hffff_ffff_ffff_ffff);
        add_req(secv_mem_pkg::MEM_OP_LD, 16'hfff8, '0);
        add_req(secv_mem_pkg::MEM_OP_LD, 16'h0028, '0);
        add_req(secv_mem_pkg::MEM_OP_LD, 16'h0000, '0);
        run_batch(1'b0);
    endtask

    // Random legal requests, aligned to their size, over every lane
    task automatic random_burst(input bit stall);
        logic [3:0] op;
        int         word;
        int         ofs;
        for (int i = 0; i < N_BURST; i++) begin
            op   = legal_ops[$urandom_range(legal_ops.size() - 1)];
            word = $urandom_range(MEM_BYTES / 8 - 1);
            ofs  = $urandom_range(7) & ~((1 << op[1:0]) - 1);
            add_req(op, ADR_WIDTH'(word * 8 + ofs), {$urandom, $urandom});
        end
        run_batch(stall);
    endtask

    task automatic test_backpressure();
        saw_req_stall = 1'b0;
        random_burst(1'b1);
        if (!saw_req_stall) begin
            stop_with_error("req_ready_o never fell while responses were held back");
        end
    endtask

    task automatic test_latency();
        int lat;
        add_req(secv_mem_pkg::MEM_OP_LD, 16'h0020, '0);
        send_all(1);
        lat = 0;
        do begin
            @(negedge clk_i);
            lat++;
        end while (!rsp_valid_o && lat < 8);
        if (lat != 2) begin
            stop_with_error($sformatf("Load response came %0d cycles after its request, not 2",
                                      lat));
        end
        check_response();
    endtask

    initial begin
        void'($urandom(62839));
        arst_n_i    = 1'b0;
        req_valid_i = 1'b0;
        req_op_i    = '0;
        req_adr_i   = '0;
        req_dat_i   = '0;
        rsp_ready_i = 1'b1;
        model       = new[MEM_BYTES];
        for (int i = 0; i < MEM_BYTES; i++) begin
            model[i] = 8'h00;
        end
        legal_ops = '{secv_mem_pkg::MEM_OP_LB, secv_mem_pkg::MEM_OP_LH,
                      secv_mem_pkg::MEM_OP_LW, secv_mem_pkg::MEM_OP_LD,
                      secv_mem_pkg::MEM_OP_LBU, secv_mem_pkg::MEM_OP_LHU,
                      secv_mem_pkg::MEM_OP_LWU, secv_mem_pkg::MEM_OP_SB,
                      secv_mem_pkg::MEM_OP_SH, secv_mem_pkg::MEM_OP_SW,
                      secv_mem_pkg::MEM_OP_SD};
        repeat (RESET_CYCLES) @(posedge clk_i);
        arst_n_i <= 1'b1;
        test_sizes();
        test_byte_selects();
        test_errors();
        random_burst(1'b0);
        test_backpressure();
        test_latency();
        @(posedge clk_i);
        $display("TEST OK");
        $finish;
    end

    // Watchdog over the summed test length
    initial begin
        repeat (4 * TEST_CYCLES + RESET_CYCLES) @(posedge clk_i);
        stop_with_error("Timeout: the tests did not finish within their cycle budget");
    end

endmodule

// File: all.f
source/secv_cfg_pkg.sv
source/secv_mem_pkg.sv
source/mem_dispatch.sv
source/mem_lane.sv
source/mem_collect.sv
source/mem_subsys_top.sv
bench/mem_subsys_sva.sv
bench/mem_subsys_tb.sv

// File: run_verilator.sh
#!/bin/sh
# Compile and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module mem_subsys_tb -o mem_subsys_sim

out=$(./obj_dir/mem_subsys_sim 2>&1 || true)
printf '%s\n' "$out"

# The run passes only when the testbench printed its pass line
printf '%s\n' "$out" | grep -qx 'TEST OK'
